/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lane_mixer
FILELIST  ?= lane_mixer.f
BUILD_DIR ?= obj_dir
# 32'h0a511570 written in decimal
SEED      ?= 173086064
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

/* lane_mixer.f */
logic/mix_pkg.sv
logic/mix_sequencer.sv
logic/chain_ops.sv
logic/diffusion_ops.sv
logic/scale_ops.sv
logic/lane_state.sv
logic/lane_mixer.sv
sim/lane_mixer_assertions.sv
sim/tb_lane_mixer.sv

/* logic/chain_ops.sv */
`timescale 1ns/1ns

module chain_ops (
    input  mix_pkg::lane_vec_t lanes,
    input  mix_pkg::op_e       op,
    output mix_pkg::lane_vec_t chain_next
);
    import mix_pkg::*;

    // lanes are swept 0 to 7 in place, so later lanes see
    // the values written earlier in the same step.
    always_comb begin
        lane_vec_t v;
        int        prev;
        int        prev2;

        v = lanes;
        for (int i = 0; i < LANES; i++) begin
            prev  = (i + LANES - 1) % LANES;
            prev2 = (i + LANES - 2) % LANES;
            case (op)
                OP_SEED: begin
                    v[i] = v[i] + lane_t'(i);
                end
                OP_RING: begin
                    v[i] = v[i] + v[prev]; // lane 0 picks up the old lane 7.
                end
                OP_TAIL: begin
                    v[i] = v[i] + v[prev] - v[prev2];
                end
                default: begin
                    v[i] = v[i];
                end
            endcase
        end
        chain_next = v;
    end

endmodule

/* logic/diffusion_ops.sv */
`timescale 1ns/1ns

module diffusion_ops (
    input  mix_pkg::lane_vec_t lanes,
    input  mix_pkg::op_e       op,
    output mix_pkg::lane_vec_t diff_next
);
    import mix_pkg::*;

    always_comb begin
        lane_vec_t v;
        int        n1;
        int        n2;
        int        n3;
        int        n4;
        int        n5;

        v = lanes;
        for (int i = 0; i < LANES; i++) begin
            n1 = (i + 1) % LANES;
            n2 = (i + 2) % LANES;
            n3 = (i + 3) % LANES;
            n4 = (i + 4) % LANES;
            n5 = (i + 5) % LANES;
            case (op)
                OP_CROSS: begin
                    v[i] = v[i] + v[n1] - v[n5]; // wrapped neighbours already updated.
                end
                OP_XOR: begin
                    v[i] = v[i] ^ (v[n3] << XOR_SHL);
                end
                OP_SHIFT: begin
                    v[i] = v[i] - (v[n2] >> BLEND_SUB_SHR) + (v[n4] >> BLEND_ADD_SHR);
                end
                default: begin
                    v[i] = v[i];
                end
            endcase
        end
        diff_next = v;
    end

endmodule

/* logic/lane_mixer.sv */
`timescale 1ns/1ns

module lane_mixer #(
    parameter int NUM_MIX_ROUNDS  = 16,
    parameter int NUM_TAIL_ROUNDS = 24
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               run,
    output mix_pkg::lane_vec_t lanes,
    output logic               iter_done
);
    import mix_pkg::*;

    op_e       op;
    logic      apply;
    lane_vec_t chain_next;
    lane_vec_t diff_next;
    lane_vec_t scale_next;

    mix_sequencer #(
        .NUM_MIX_ROUNDS  (NUM_MIX_ROUNDS),
        .NUM_TAIL_ROUNDS (NUM_TAIL_ROUNDS)
    ) u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .op        (op),
        .apply     (apply),
        .iter_done (iter_done)
    );

    lane_state u_state (
        .clk        (clk),
        .arst_n     (arst_n),
        .apply      (apply),
        .op         (op),
        .chain_next (chain_next),
        .diff_next  (diff_next),
        .scale_next (scale_next),
        .lanes      (lanes)
    );

    chain_ops u_chain (
        .lanes      (lanes),
        .op         (op),
        .chain_next (chain_next)
    );

    diffusion_ops u_diff (
        .lanes     (lanes),
        .op        (op),
        .diff_next (diff_next)
    );

    scale_ops u_scale (
        .lanes      (lanes),
        .op         (op),
        .scale_next (scale_next)
    );

endmodule

/* logic/lane_state.sv */
`timescale 1ns/1ns

module lane_state (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               apply,
    input  mix_pkg::op_e       op,
    input  mix_pkg::lane_vec_t chain_next,
    input  mix_pkg::lane_vec_t diff_next,
    input  mix_pkg::lane_vec_t scale_next,
    output mix_pkg::lane_vec_t lanes
);
    import mix_pkg::*;

    lane_vec_t lanes_d;

    // pick the operator block that owns this opcode.
    always_comb begin
        case (op)
            OP_SEED,
            OP_RING,
            OP_TAIL:    lanes_d = chain_next;
            OP_CROSS,
            OP_XOR,
            OP_SHIFT:   lanes_d = diff_next;
            OP_SCALE_A,
            OP_SCALE_B: lanes_d = scale_next;
            default:    lanes_d = lanes;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LANES; i++) begin
                lanes[i] <= lane_t'(i); // lane i starts at i.
            end
        end else if (apply) begin
            lanes <= lanes_d;
        end
    end

endmodule

/* logic/mix_pkg.sv */
package mix_pkg;

    localparam int LANES  = 8;
    localparam int LANE_W = 32;

    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [LANES-1:0][LANE_W-1:0] lane_vec_t;

    // one whole-lane operation per step.
    typedef enum logic [2:0] {
        OP_SEED,
        OP_RING,
        OP_CROSS,
        OP_XOR,
        OP_SHIFT,
        OP_TAIL,
        OP_SCALE_A,
        OP_SCALE_B
    } op_e;

    typedef enum logic [2:0] {
        PH_SEED,
        PH_RING,
        PH_CROSS,
        PH_XOR,
        PH_SHIFT,
        PH_TAIL,
        PH_SCALE_A,
        PH_SCALE_B
    } phase_e;

    localparam int XOR_SHL       = 16;
    localparam int BLEND_SUB_SHR = 17;
    localparam int BLEND_ADD_SHR = 12;

    // first scale pass uses small primes.
    localparam lane_t SCALE_A_MUL [LANES] = '{
        32'd2, 32'd3, 32'd5, 32'd7, 32'd11, 32'd13, 32'd17, 32'd19
    };
    localparam lane_t SCALE_A_ADD [LANES] = '{
        32'd3, 32'd5, 32'd7, 32'd11, 32'd13, 32'd17, 32'd19, 32'd23
    };

    // second pass adds the cube of the lane index.
    localparam lane_t SCALE_B_MUL [LANES] = '{
        32'd2, 32'd3, 32'd3, 32'd3, 32'd5, 32'd13, 32'd35, 32'd87
    };
    localparam lane_t SCALE_B_ADD [LANES] = '{
        32'd0, 32'd1, 32'd8, 32'd27, 32'd64, 32'd125, 32'd216, 32'd343
    };

endpackage

/* logic/mix_sequencer.sv */
`timescale 1ns/1ns

module mix_sequencer #(
    parameter int NUM_MIX_ROUNDS  = 16,
    parameter int NUM_TAIL_ROUNDS = 24
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          run,
    output mix_pkg::op_e  op,
    output logic          apply,
    output logic          iter_done
);
    import mix_pkg::*;

    localparam int MIX_W  = (NUM_MIX_ROUNDS > 1) ? $clog2(NUM_MIX_ROUNDS) : 1;
    localparam int TAIL_W = (NUM_TAIL_ROUNDS > 1) ? $clog2(NUM_TAIL_ROUNDS) : 1;

    localparam logic [MIX_W-1:0]  MIX_LAST  = MIX_W'(NUM_MIX_ROUNDS - 1);
    localparam logic [TAIL_W-1:0] TAIL_LAST = TAIL_W'(NUM_TAIL_ROUNDS - 1);

    phase_e              phase;
    logic [MIX_W-1:0]    mix_cnt;
    logic [TAIL_W-1:0]   tail_cnt;

    assign apply = run; // run low freezes phase and lanes.

    always_comb begin
        case (phase)
            PH_SEED:    op = OP_SEED;
            PH_RING:    op = OP_RING;
            PH_CROSS:   op = OP_CROSS;
            PH_XOR:     op = OP_XOR;
            PH_SHIFT:   op = OP_SHIFT;
            PH_TAIL:    op = OP_TAIL;
            PH_SCALE_A: op = OP_SCALE_A;
            PH_SCALE_B: op = OP_SCALE_B;
            default:    op = OP_SEED;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= PH_SEED;
            mix_cnt   <= '0;
            tail_cnt  <= '0;
            iter_done <= 1'b0;
        end else begin
            iter_done <= run && (phase == PH_SCALE_B); // last step lands this edge.
            if (run) begin
                case (phase)
                    PH_SEED:  phase <= PH_RING;
                    PH_RING:  phase <= PH_CROSS;
                    PH_CROSS: phase <= PH_XOR;
                    PH_XOR:   phase <= PH_SHIFT;
                    PH_SHIFT: begin
                        if (mix_cnt == MIX_LAST) begin
                            mix_cnt <= '0;
                            phase   <= PH_TAIL;
                        end else begin
                            mix_cnt <= mix_cnt + 1'b1;
                            phase   <= PH_CROSS; // next mix round.
                        end
                    end
                    PH_TAIL: begin
                        if (tail_cnt == TAIL_LAST) begin
                            tail_cnt <= '0;
                            phase    <= PH_SCALE_A;
                        end else begin
                            tail_cnt <= tail_cnt + 1'b1;
                        end
                    end
                    PH_SCALE_A: phase <= PH_SCALE_B;
                    PH_SCALE_B: phase <= PH_SEED; // wraps into next iteration.
                    default:    phase <= PH_SEED;
                endcase
            end
        end
    end

endmodule

/* logic/scale_ops.sv */
`timescale 1ns/1ns

module scale_ops (
    input  mix_pkg::lane_vec_t lanes,
    input  mix_pkg::op_e       op,
    output mix_pkg::lane_vec_t scale_next
);
    import mix_pkg::*;

    // each lane scales on its own.
    always_comb begin
        lane_t mul;
        lane_t add;

        for (int i = 0; i < LANES; i++) begin
            if (op == OP_SCALE_B) begin
                mul = SCALE_B_MUL[i];
                add = SCALE_B_ADD[i];
            end else begin
                mul = SCALE_A_MUL[i];
                add = SCALE_A_ADD[i];
            end
            scale_next[i] = lanes[i] * mul + add; // wraps at 32 bits.
        end
    end

endmodule

/* sim/lane_mixer_assertions.sv */
`timescale 1ns/1ns

module lane_mixer_assertions (
    input logic            clk,
    input logic            arst_n,
    input logic            run,
    input logic            apply,
    input logic            iter_done,
    input mix_pkg::phase_e phase
);
    import mix_pkg::*;

    int fault_count = 0; // failed assertions so far.

    // one pulse per finished iteration.
    done_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        iter_done |=> !iter_done)
        else begin
            $error("iter_done stayed high for two cycles");
            fault_count++;
        end

    apply_follows_run: assert property (@(posedge clk) disable iff (!arst_n)
        apply == run)
        else begin
            $error("apply differs from run");
            fault_count++;
        end

    phase_legal: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(phase) && (phase inside {PH_SEED, PH_RING, PH_CROSS, PH_XOR,
            PH_SHIFT, PH_TAIL, PH_SCALE_A, PH_SCALE_B}))
        else begin
            $error("sequencer phase holds an illegal value");
            fault_count++;
        end

endmodule

bind mix_sequencer lane_mixer_assertions u_checks (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .apply     (apply),
    .iter_done (iter_done),
    .phase     (phase)
);

/* sim/tb_lane_mixer.sv */
`timescale 1ns/1ns

module tb_lane_mixer #(
    parameter int unsigned SEED = 32'h0a511570
);
    import mix_pkg::*;

    localparam int MIX_ROUNDS    = 16;
    localparam int TAIL_ROUNDS   = 24;
    localparam int ITER_CYCLES   = 2 + 3 * MIX_ROUNDS + TAIL_ROUNDS + 2;
    localparam int DONE_LIMIT    = 4 * ITER_CYCLES;
    localparam int RAND_CYCLES   = 400;
    localparam int PLANNED_ITERS = 1 + 20 + RAND_CYCLES / ITER_CYCLES + 1 + 1;
    localparam int WDOG_CYCLES   = PLANNED_ITERS * ITER_CYCLES * 2 + 200;

    logic      clk;
    logic      arst_n;
    logic      run;
    lane_vec_t lanes;
    logic      iter_done;

    lane_vec_t base_lanes; // start point of the running iteration.
    int        errors = 0;
    int        iters_checked = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;

    lane_mixer uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .lanes     (lanes),
        .iter_done (iter_done)
    );

    function automatic lane_vec_t index_lanes();
        lane_vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = lane_t'(i);
        end
        return v;
    endfunction

    // one whole iteration where every step sweeps lane 0 to 7 in place.
    function automatic lane_vec_t model_iteration(input lane_vec_t start);
        lane_vec_t v;
        v = start;
        for (int i = 0; i < LANES; i++) begin
            v[i] = v[i] + lane_t'(i);
        end
        for (int i = 0; i < LANES; i++) begin
            v[i] = v[i] + v[(i + 7) % LANES];
        end
        for (int r = 0; r < MIX_ROUNDS; r++) begin
            for (int i = 0; i < LANES; i++) begin
                v[i] = v[i] + v[(i + 1) % LANES] - v[(i + 5) % LANES];
            end
            for (int i = 0; i < LANES; i++) begin
                v[i] = v[i] ^ (v[(i + 3) % LANES] << XOR_SHL);
            end
            for (int i = 0; i < LANES; i++) begin
                v[i] = v[i] - (v[(i + 2) % LANES] >> BLEND_SUB_SHR)
                     + (v[(i + 4) % LANES] >> BLEND_ADD_SHR);
            end
        end
        for (int r = 0; r < TAIL_ROUNDS; r++) begin
            for (int i = 0; i < LANES; i++) begin
                v[i] = v[i] + v[(i + 7) % LANES] - v[(i + 6) % LANES];
            end
        end
        for (int i = 0; i < LANES; i++) begin
            v[i] = v[i] * SCALE_A_MUL[i] + SCALE_A_ADD[i];
        end
        for (int i = 0; i < LANES; i++) begin
            v[i] = v[i] * SCALE_B_MUL[i] + SCALE_B_ADD[i];
        end
        return v;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // compares every finished iteration with the model.
    always @(negedge clk) begin
        lane_vec_t want;
        if (!arst_n) begin
            base_lanes = index_lanes();
        end else if (iter_done) begin
            want = model_iteration(base_lanes);
            for (int i = 0; i < LANES; i++) begin
                assert (lanes[i] == want[i]) else begin
                    $display("FAILED lanes[%0d] expected %08h actual %08h",
                             i, want[i], lanes[i]);
                    errors++;
                end
            end
            base_lanes = want;
            iters_checked++;
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic wait_done(output int cycles);
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < DONE_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = iter_done;
        end
        if (!seen) begin
            $display("iter_done did not arrive within %0d cycles", DONE_LIMIT);
            errors++;
        end
    endtask

    task automatic check_interval(input int cycles);
        assert (cycles == ITER_CYCLES) else begin
            $display("FAILED iter_done interval expected %08h actual %08h",
                     ITER_CYCLES, cycles);
            errors++;
        end
    endtask

    task automatic check_reset_lanes();
        for (int i = 0; i < LANES; i++) begin
            assert (lanes[i] == lane_t'(i)) else begin
                $display("FAILED lanes[%0d] expected %08h actual %08h",
                         i, lane_t'(i), lanes[i]);
                errors++;
            end
        end
        assert (iter_done == 1'b0) else begin
            $display("FAILED iter_done expected 0 actual %0h", iter_done);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        #1; // lets the comparator finish this edge.
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - errors_before);
        end
    endtask

    initial begin
        int        cycles;
        int        mark;
        int        iters_before;
        logic      prev_run;
        lane_vec_t prev_lanes;

        arst_n = 1'b0;
        run    = 1'b0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        mark = errors;
        repeat (10) begin
            @(negedge clk);
            check_reset_lanes();
        end
        close_test("reset_state", mark);

        mark = errors;
        @(posedge clk);
        run <= 1'b1;
        wait_done(cycles);
        check_interval(cycles);
        close_test("first_iteration", mark);

        mark = errors;
        repeat (20) begin
            wait_done(cycles);
            check_interval(cycles);
        end
        close_test("back_to_back", mark);

        mark = errors;
        iters_before = iters_checked;
        prev_run = 1'b1;
        prev_lanes = lanes;
        repeat (RAND_CYCLES) begin
            @(posedge clk);
            run <= ($urandom % 100) < 60;
            @(negedge clk);
            if (!prev_run) begin
                assert (lanes == prev_lanes) else begin
                    $display("FAILED lanes expected %h actual %h", prev_lanes, lanes);
                    errors++;
                end
            end
            prev_run = run;
            prev_lanes = lanes;
        end
        @(posedge clk);
        run <= 1'b1;
        wait_done(cycles);
        assert (iters_checked - iters_before >= 2) else begin
            $display("too few iterations finished while run was toggled");
            errors++;
        end
        close_test("random_run", mark);

        mark = errors;
        repeat (30) @(posedge clk);
        arst_n <= 1'b0;
        run    <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_reset_lanes();
        @(posedge clk);
        arst_n <= 1'b1;
        run    <= 1'b1;
        wait_done(cycles);
        check_interval(cycles);
        close_test("mid_reset", mark);

        $display("tests passed %0d failed %0d, iterations checked %0d",
                 tests_passed, tests_failed, iters_checked);
        if (tests_failed == 0 && errors == 0 && uut.u_seq.u_checks.fault_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
